//--- Makefile
VERILATOR  := verilator
TOP        := camera_pipeline_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/camera_settings.svh
`ifndef CAMERA_SETTINGS_SVH
`define CAMERA_SETTINGS_SVH

// Raw pixel and line coordinates, up to 256 by 256
`define CAM_COORD_W 8

// Raw Bayer and RGB sample width
`define CAM_PIXEL_W 10

// Per-channel metering accumulator
`define CAM_SUM_W 24

`endif

//--- sim.f
+incdir+include
source/camera_reg_pkg.sv
source/camera_pixel_pkg.sv
source/capture_registers.sv
source/frame_crop.sv
source/bayer_demosaic.sv
source/color_metering.sv
source/camera_pipeline.sv
tb/camera_pipeline_chk.sv
tb/camera_pipeline_tb.sv

//--- source/bayer_demosaic.sv
`timescale 1ns/1ps
`include "camera_settings.svh"

module bayer_demosaic
    import camera_pixel_pkg::*;
(
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,
    input  bayer_pixel_t bayer_i,
    output rgb_pixel_t   rgb_o
);

    localparam int unsigned DEPTH = 1 << `CAM_COORD_W;

    logic [`CAM_PIXEL_W-1:0] line_buf [DEPTH]; // Even row, R G R G ...
    logic                    line_valid_d;
    logic                    frame_start;
    logic                    line_start;
    logic                    line_end;
    logic [`CAM_COORD_W-1:0] col_count;
    logic [`CAM_COORD_W-1:0] col_pos;
    logic                    row_odd;
    logic [`CAM_PIXEL_W-1:0] stored;
    logic [`CAM_PIXEL_W-1:0] red_hold;
    logic [`CAM_PIXEL_W-1:0] green_hold;   // G of the odd row
    logic [`CAM_PIXEL_W:0]   green_sum;
    logic                    quad_done;
    logic                    frame_valid_q;
    logic                    pixel_valid_q;
    logic [`CAM_PIXEL_W-1:0] red_q;
    logic [`CAM_PIXEL_W-1:0] green_q;
    logic [`CAM_PIXEL_W-1:0] blue_q;

    assign frame_start = bayer_i.frame_valid && !frame_valid_q;
    assign line_start  = bayer_i.line_valid && !line_valid_d;
    assign line_end    = !bayer_i.line_valid && line_valid_d;
    assign col_pos     = line_start ? '0 : col_count;
    assign stored      = line_buf[col_pos];
    assign green_sum   = stored + green_hold;
    assign quad_done   = bayer_i.line_valid && row_odd && col_pos[0]; // B sample

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            line_valid_d  <= 1'b0;
            col_count     <= '0;
            row_odd       <= 1'b0;
            frame_valid_q <= 1'b0;
            pixel_valid_q <= 1'b0;
        end else begin
            line_valid_d  <= bayer_i.line_valid;
            frame_valid_q <= bayer_i.frame_valid;
            pixel_valid_q <= quad_done;
            if (bayer_i.line_valid) begin
                col_count <= col_pos + 1'b1;
            end
            if (frame_start) begin
                row_odd <= 1'b0;
            end else if (line_end) begin
                row_odd <= !row_odd;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (bayer_i.line_valid && !row_odd) begin
            line_buf[col_pos] <= bayer_i.data;
        end
        if (bayer_i.line_valid && row_odd && !col_pos[0]) begin
            red_hold   <= stored;       // R from the row above
            green_hold <= bayer_i.data;
        end
        if (quad_done) begin
            red_q   <= red_hold;
            green_q <= green_sum[`CAM_PIXEL_W:1]; // Average of both G
            blue_q  <= bayer_i.data;
        end
    end

    assign rgb_o = {frame_valid_q, pixel_valid_q, red_q, green_q, blue_q};

endmodule

//--- source/camera_pipeline.sv
`timescale 1ns/1ps

module camera_pipeline
    import camera_reg_pkg::*, camera_pixel_pkg::*;
(
    input  logic           mipi_byte_clock,
    input  logic           mipi_byte_reset_n,
    input  bayer_pixel_t   bayer_i,
    input  camera_opcode_e opcode_i,
    input  logic [7:0]     operand_i,
    input  logic           operand_valid_i,
    output logic [7:0]     response_o
);

    camera_config_t camera_config;
    logic           capture_start;
    logic           capture_pending;
    bayer_pixel_t   cropped;         // Window of the armed frame
    rgb_pixel_t     rgb;             // Half resolution
    metering_t      metering;

    capture_registers capture_registers_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .opcode_i          (opcode_i),
        .operand_i         (operand_i),
        .operand_valid_i   (operand_valid_i),
        .metering_i        (metering),
        .capture_pending_i (capture_pending),
        .config_o          (camera_config),
        .capture_start_o   (capture_start),
        .response_o        (response_o)
    );

    frame_crop frame_crop_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .bayer_i           (bayer_i),
        .config_i          (camera_config),
        .capture_start_i   (capture_start),
        .bayer_o           (cropped),
        .capture_pending_o (capture_pending)
    );

    bayer_demosaic bayer_demosaic_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .bayer_i           (cropped),
        .rgb_o             (rgb)
    );

    color_metering color_metering_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .rgb_i             (rgb),
        .meter_shift_i     (camera_config.meter_shift),
        .metering_o        (metering)
    );

endmodule

//--- source/camera_pixel_pkg.sv
`include "camera_settings.svh"

package camera_pixel_pkg;

    typedef struct packed {
        logic                    frame_valid;
        logic                    line_valid;
        logic [`CAM_PIXEL_W-1:0] data;
    } bayer_pixel_t;

    typedef struct packed {
        logic                    frame_valid;
        logic                    pixel_valid; // One strobe per quad
        logic [`CAM_PIXEL_W-1:0] red;
        logic [`CAM_PIXEL_W-1:0] green;
        logic [`CAM_PIXEL_W-1:0] blue;
    } rgb_pixel_t;

    typedef struct packed {
        logic       ready;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } metering_t;

endpackage

//--- source/camera_reg_pkg.sv
`include "camera_settings.svh"

package camera_reg_pkg;

    typedef enum logic [7:0] {
        OP_CROP_X_START  = 8'h01,
        OP_CROP_X_END    = 8'h02,
        OP_CROP_Y_START  = 8'h03,
        OP_CROP_Y_END    = 8'h04,
        OP_METER_SHIFT   = 8'h05,
        OP_START_CAPTURE = 8'h10, // Arms the next frame
        OP_READ_STATUS   = 8'h20,
        OP_READ_RED      = 8'h21,
        OP_READ_GREEN    = 8'h22,
        OP_READ_BLUE     = 8'h23
    } camera_opcode_e;

    typedef struct packed {
        logic [`CAM_COORD_W-1:0] x_start;
        logic [`CAM_COORD_W-1:0] x_end;   // Exclusive
        logic [`CAM_COORD_W-1:0] y_start;
        logic [`CAM_COORD_W-1:0] y_end;   // Exclusive
        logic [4:0]              meter_shift;
    } camera_config_t;

endpackage

//--- source/capture_registers.sv
`timescale 1ns/1ps

module capture_registers
    import camera_reg_pkg::*, camera_pixel_pkg::*;
(
    input  logic           mipi_byte_clock,
    input  logic           mipi_byte_reset_n,

    input  camera_opcode_e opcode_i,
    input  logic [7:0]     operand_i,
    input  logic           operand_valid_i,

    input  metering_t      metering_i,
    input  logic           capture_pending_i,

    output camera_config_t config_o,
    output logic           capture_start_o,
    output logic [7:0]     response_o
);

    // Write decode
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            config_o        <= '0; // Empty window until programmed
            capture_start_o <= 1'b0;
        end else begin
            capture_start_o <= 1'b0;
            if (operand_valid_i) begin
                case (opcode_i)
                    OP_CROP_X_START: begin
                        config_o.x_start <= operand_i;
                    end
                    OP_CROP_X_END: begin
                        config_o.x_end <= operand_i;
                    end
                    OP_CROP_Y_START: begin
                        config_o.y_start <= operand_i;
                    end
                    OP_CROP_Y_END: begin
                        config_o.y_end <= operand_i;
                    end
                    OP_METER_SHIFT: begin
                        config_o.meter_shift <= operand_i[4:0];
                    end
                    OP_START_CAPTURE: begin
                        capture_start_o <= 1'b1; // Operand ignored
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read mux, one cycle behind the opcode
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o <= 8'h00;
        end else begin
            case (opcode_i)
                OP_CROP_X_START: response_o <= config_o.x_start;
                OP_CROP_X_END:   response_o <= config_o.x_end;
                OP_CROP_Y_START: response_o <= config_o.y_start;
                OP_CROP_Y_END:   response_o <= config_o.y_end;
                OP_METER_SHIFT:  response_o <= {3'b000, config_o.meter_shift};
                OP_READ_STATUS:  response_o <= {6'b0, capture_pending_i, metering_i.ready};
                OP_READ_RED:     response_o <= metering_i.red;
                OP_READ_GREEN:   response_o <= metering_i.green;
                OP_READ_BLUE:    response_o <= metering_i.blue;
                default:         response_o <= 8'h00; // Start capture reads zero
            endcase
        end
    end

endmodule

//--- source/color_metering.sv
`timescale 1ns/1ps
`include "camera_settings.svh"

module color_metering
    import camera_pixel_pkg::*;
(
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  rgb_pixel_t rgb_i,
    input  logic [4:0] meter_shift_i,
    output metering_t  metering_o
);

    logic                  frame_valid_d;
    logic                  frame_start;
    logic                  frame_end;
    logic [`CAM_SUM_W-1:0] red_sum;
    logic [`CAM_SUM_W-1:0] green_sum;
    logic [`CAM_SUM_W-1:0] blue_sum;

    // Average as a 10-bit sample, top 8 bits kept
    function automatic logic [7:0] meter_byte(input logic [`CAM_SUM_W-1:0] sum,
                                              input logic [4:0] shift);
        logic [`CAM_SUM_W-1:0] shifted;
        logic [9:0]            scaled;
        shifted = sum >> shift;
        scaled  = shifted[9:0];
        return scaled[9:2];
    endfunction

    assign frame_start = rgb_i.frame_valid && !frame_valid_d;
    assign frame_end   = !rgb_i.frame_valid && frame_valid_d;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_d <= 1'b0;
            metering_o    <= '0;
        end else begin
            frame_valid_d <= rgb_i.frame_valid;
            if (frame_start) begin
                metering_o.ready <= 1'b0;  // New frame in progress
            end else if (frame_end) begin
                metering_o.ready <= 1'b1;
                metering_o.red   <= meter_byte(red_sum, meter_shift_i);
                metering_o.green <= meter_byte(green_sum, meter_shift_i);
                metering_o.blue  <= meter_byte(blue_sum, meter_shift_i);
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (frame_start) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (rgb_i.pixel_valid) begin
            red_sum   <= red_sum + rgb_i.red;
            green_sum <= green_sum + rgb_i.green;
            blue_sum  <= blue_sum + rgb_i.blue;
        end
    end

endmodule

//--- source/frame_crop.sv
`timescale 1ns/1ps
`include "camera_settings.svh"

module frame_crop
    import camera_reg_pkg::*, camera_pixel_pkg::*;
(
    input  logic           mipi_byte_clock,
    input  logic           mipi_byte_reset_n,
    input  bayer_pixel_t   bayer_i,
    input  camera_config_t config_i,
    input  logic           capture_start_i,
    output bayer_pixel_t   bayer_o,
    output logic           capture_pending_o
);

    logic                    frame_valid_d;
    logic                    line_valid_d;
    logic                    frame_start;
    logic                    line_start;
    logic                    line_end;
    logic [`CAM_COORD_W-1:0] x_count;
    logic [`CAM_COORD_W-1:0] y_count;
    logic [`CAM_COORD_W-1:0] x_pos;
    logic                    accepted;      // Doubles as the output frame_valid
    logic                    frame_active;
    logic                    in_window;
    logic                    line_valid_q;
    logic [`CAM_PIXEL_W-1:0] data_q;

    assign frame_start  = bayer_i.frame_valid && !frame_valid_d;
    assign line_start   = bayer_i.line_valid && !line_valid_d;
    assign line_end     = !bayer_i.line_valid && line_valid_d;
    assign x_pos        = line_start ? '0 : x_count; // First pixel of a line is x 0
    assign frame_active = accepted || (frame_start && capture_pending_o);
    assign in_window    = (x_pos >= config_i.x_start) && (x_pos < config_i.x_end) &&
                          (y_count >= config_i.y_start) && (y_count < config_i.y_end);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_d     <= 1'b0;
            line_valid_d      <= 1'b0;
            x_count           <= '0;
            y_count           <= '0;
            capture_pending_o <= 1'b0;
            accepted          <= 1'b0;
            line_valid_q      <= 1'b0;
        end else begin
            frame_valid_d <= bayer_i.frame_valid;
            line_valid_d  <= bayer_i.line_valid;
            if (bayer_i.line_valid) begin
                x_count <= x_pos + 1'b1;
            end
            if (!bayer_i.frame_valid) begin
                y_count <= '0;
            end else if (line_end) begin
                y_count <= y_count + 1'b1;
            end
            if (frame_start && capture_pending_o) begin
                capture_pending_o <= 1'b0; // Frame taken
            end else if (capture_start_i) begin
                capture_pending_o <= 1'b1;
            end
            accepted     <= bayer_i.frame_valid && frame_active;
            line_valid_q <= bayer_i.line_valid && frame_active && in_window;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_q <= bayer_i.data;
    end

    assign bayer_o = {accepted, line_valid_q, data_q};

endmodule

//--- tb/camera_pipeline_chk.sv
`timescale 1ns/1ps

module camera_pipeline_chk
    import camera_pixel_pkg::*;
(
    input logic         mipi_byte_clock,
    input logic         mipi_byte_reset_n,
    input logic         capture_start_i,
    input bayer_pixel_t cropped_i,
    input rgb_pixel_t   rgb_i,
    input metering_t    metering_i
);

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        capture_start_i |=> !capture_start_i) // Single-cycle arm strobe
        else $error("capture_start high for two cycles");

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        cropped_i.line_valid |-> cropped_i.frame_valid)
        else $error("cropped line_valid outside frame_valid");

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        rgb_i.pixel_valid |-> rgb_i.frame_valid)
        else $error("pixel_valid outside frame_valid");

    // Ready drops one cycle after the RGB frame starts
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        $fell(metering_i.ready) |-> $past(rgb_i.frame_valid) && !$past(rgb_i.frame_valid, 2))
        else $error("ready fell without a frame start");

endmodule

bind camera_pipeline camera_pipeline_chk camera_pipeline_chk_i (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .capture_start_i   (capture_start),
    .cropped_i         (cropped),
    .rgb_i             (rgb),
    .metering_i        (metering)
);

//--- tb/camera_pipeline_tb.sv
`timescale 1ns/1ps
`include "camera_settings.svh"

module camera_pipeline_tb
    import camera_reg_pkg::*, camera_pixel_pkg::*;
();

    localparam int FRAME_CYCLES   = 2 + 12 * (16 + 2) + 5; // 16 by 12 frame with 2 idle per line
    localparam int TIMEOUT_CYCLES = 2 * 5 * FRAME_CYCLES + 200;

    logic                    mipi_byte_clock = 1'b0;
    logic                    mipi_byte_reset_n;
    bayer_pixel_t            bayer;
    camera_opcode_e          opcode;
    logic [7:0]              operand;
    logic                    operand_valid;
    logic [7:0]              response;
    logic [31:0]             lfsr_state;
    logic [`CAM_PIXEL_W-1:0] raw [16][16];      // Last frame sent as [y][x]
    logic [`CAM_PIXEL_W-1:0] const_red;
    logic [`CAM_PIXEL_W-1:0] const_green;
    logic [`CAM_PIXEL_W-1:0] const_blue;
    int                      win_x0;
    int                      win_x1;
    int                      win_y0;
    int                      win_y1;
    int                      shift_amount;
    logic [7:0]              exp_red;
    logic [7:0]              exp_green;
    logic [7:0]              exp_blue;
    int                      cycle_count = 0;

    camera_pipeline camera_pipeline_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .bayer_i           (bayer),
        .opcode_i          (opcode),
        .operand_i         (operand),
        .operand_valid_i   (operand_valid),
        .response_o        (response)
    );

    always #20 mipi_byte_clock = ~mipi_byte_clock;

    always @(posedge mipi_byte_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timed out after %0d cycles before the tests finished", cycle_count);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic random_sample(output logic [`CAM_PIXEL_W-1:0] value);
        value = '0;
        for (int i = 0; i < `CAM_PIXEL_W; i++) begin
            value      = {value[`CAM_PIXEL_W-2:0], lfsr_state[0]}; // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic next_cycle();
        @(posedge mipi_byte_clock);
        #2;
    endtask

    task automatic write_reg(input camera_opcode_e op, input logic [7:0] value);
        next_cycle();
        opcode        = op;
        operand       = value;
        operand_valid = 1'b1;
        next_cycle();
        operand_valid = 1'b0;
    endtask

    task automatic read_reg(input camera_opcode_e op, output logic [7:0] value);
        next_cycle();
        opcode = op;
        next_cycle();
        value = response; // Registered one cycle behind the opcode
    endtask

    task automatic expect_reg(input camera_opcode_e op, input logic [7:0] expected);
        logic [7:0] value;
        read_reg(op, value);
        check_value($sformatf("response_o (%s)", op.name()), {24'h0, value}, {24'h0, expected});
    endtask

    task automatic wait_ready();
        logic [7:0] status;
        status = 8'h00;
        while (!status[0]) begin
            read_reg(OP_READ_STATUS, status);
        end
    endtask

    task automatic set_window(input int x0, input int x1, input int y0, input int y1,
                              input int shift);
        win_x0       = x0;
        win_x1       = x1;
        win_y0       = y0;
        win_y1       = y1;
        shift_amount = shift;
        write_reg(OP_CROP_X_START, 8'(x0));
        write_reg(OP_CROP_X_END, 8'(x1));
        write_reg(OP_CROP_Y_START, 8'(y0));
        write_reg(OP_CROP_Y_END, 8'(y1));
        write_reg(OP_METER_SHIFT, 8'(shift));
    endtask

    task automatic send_frame(input int width, input int height, input int idle,
                              input bit use_lfsr);
        logic [`CAM_PIXEL_W-1:0] value;
        next_cycle();
        bayer.frame_valid = 1'b1;
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                if (use_lfsr) begin
                    random_sample(value);
                end else if (y % 2 == 0) begin
                    value = (x % 2 == 0) ? const_red : const_green;
                end else begin
                    value = (x % 2 == 0) ? const_green : const_blue;
                end
                raw[y][x] = value;
                next_cycle();
                bayer.line_valid = 1'b1;
                bayer.data       = value;
            end
            repeat (idle) begin
                next_cycle();
                bayer.line_valid = 1'b0;
            end
        end
        next_cycle();
        bayer.frame_valid = 1'b0;
        repeat (4) next_cycle(); // Gap between frames
    endtask

    function automatic logic [7:0] average_byte(input int sum, input int shift);
        int scaled;
        scaled = (sum >> shift) % 1024; // 10-bit average
        return 8'(scaled / 4);
    endfunction

    // Crop, RGGB quads at half resolution, then whole-window averages
    task automatic compute_expected();
        int red_sum;
        int green_sum;
        int blue_sum;
        red_sum   = 0;
        green_sum = 0;
        blue_sum  = 0;
        for (int qy = win_y0; qy < win_y1; qy += 2) begin
            for (int qx = win_x0; qx < win_x1; qx += 2) begin
                red_sum   += int'(raw[qy][qx]);
                green_sum += (int'(raw[qy][qx + 1]) + int'(raw[qy + 1][qx])) / 2;
                blue_sum  += int'(raw[qy + 1][qx + 1]);
            end
        end
        exp_red   = average_byte(red_sum, shift_amount);
        exp_green = average_byte(green_sum, shift_amount);
        exp_blue  = average_byte(blue_sum, shift_amount);
    endtask

    task automatic check_colours();
        expect_reg(OP_READ_RED, exp_red);
        expect_reg(OP_READ_GREEN, exp_green);
        expect_reg(OP_READ_BLUE, exp_blue);
    endtask

    task automatic reset_value_reads();
        expect_reg(OP_READ_STATUS, 8'h00);
        expect_reg(OP_CROP_X_START, 8'h00);
        expect_reg(OP_CROP_X_END, 8'h00);
        expect_reg(OP_CROP_Y_START, 8'h00);
        expect_reg(OP_CROP_Y_END, 8'h00);
        expect_reg(OP_METER_SHIFT, 8'h00);
        expect_reg(OP_READ_RED, 8'h00);
        expect_reg(OP_READ_GREEN, 8'h00);
        expect_reg(OP_READ_BLUE, 8'h00);
    endtask

    task automatic register_readback();
        write_reg(OP_CROP_X_START, 8'h12);
        write_reg(OP_CROP_X_END, 8'h34);
        write_reg(OP_CROP_Y_START, 8'h56);
        write_reg(OP_CROP_Y_END, 8'h78);
        write_reg(OP_METER_SHIFT, 8'hE9); // Only 5 bits kept
        expect_reg(OP_CROP_X_START, 8'h12);
        expect_reg(OP_CROP_X_END, 8'h34);
        expect_reg(OP_CROP_Y_START, 8'h56);
        expect_reg(OP_CROP_Y_END, 8'h78);
        expect_reg(OP_METER_SHIFT, 8'h09);
        next_cycle();
        opcode  = OP_CROP_X_START;
        operand = 8'hAB;
        next_cycle(); // operand_valid stays low
        expect_reg(OP_CROP_X_START, 8'h12);
    endtask

    task automatic capture_arming();
        send_frame(16, 12, 2, 1'b0);
        expect_reg(OP_READ_STATUS, 8'h00);
        write_reg(OP_START_CAPTURE, 8'h00);
        expect_reg(OP_READ_STATUS, 8'h02);
        send_frame(16, 12, 2, 1'b0);
        wait_ready();
        expect_reg(OP_READ_STATUS, 8'h01);
    endtask

    task automatic constant_frame_capture();
        const_red   = 10'h190;
        const_green = 10'h0C8;
        const_blue  = 10'h320;
        set_window(0, 4, 0, 4, 2);
        write_reg(OP_START_CAPTURE, 8'h00);
        send_frame(16, 12, 2, 1'b0);
        compute_expected();
        wait_ready();
        check_colours();
    endtask

    task automatic random_frame_capture();
        set_window(2, 12, 4, 10, 1); // Shifted sums exceed 10 bits
        write_reg(OP_START_CAPTURE, 8'h00);
        send_frame(16, 12, 2, 1'b1);
        compute_expected();
        wait_ready();
        check_colours();
    endtask

    task automatic repeated_capture();
        set_window(2, 12, 4, 10, 2);
        write_reg(OP_START_CAPTURE, 8'h00);
        fork
            send_frame(16, 12, 2, 1'b1);
            begin
                repeat (12) next_cycle();
                expect_reg(OP_READ_STATUS, 8'h00); // Ready cleared by the new frame
            end
        join
        compute_expected();
        wait_ready();
        check_colours();
    endtask

    initial begin
        mipi_byte_reset_n = 1'b0;
        bayer             = '0;
        opcode            = OP_READ_STATUS;
        operand           = 8'h00;
        operand_valid     = 1'b0;
        lfsr_state        = 32'h926ab1c2;
        repeat (5) @(posedge mipi_byte_clock);
        #2;
        mipi_byte_reset_n = 1'b1;
        reset_value_reads();
        register_readback();
        capture_arming();
        constant_frame_capture();
        random_frame_capture();
        repeated_capture();
        $display("All checks passed");
        $finish;
    end

endmodule
